//--- Makefile
# Verilator build and run of the network adapter testbench
# make sim passes only if the log holds the pass line

VERILATOR ?= verilator
TOP       ?= na_tb
FILELIST  ?= na_subsys.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/na_tb_table.svh
// stimulus and expected answers for the network adapter testbench, one cycle per row
// included inside na_tb, which owns add_row and the row type
// columns: op, byte address, write data, expected rdata, expected ack, expected err
task automatic build_table();
   logic [31:0] feat;
   feat    = 32'h0;
   feat[0] = na_pkg::ENABLE_MPSIMPLE;  // bit 0 mp simple
   feat[1] = na_pkg::ENABLE_DMA;       // bit 1 dma
   // fixed conf words, holes read zero
   add_row(OP_READ,  16'h0000, 32'h0, 32'(TB_TILE), 1'b1, 1'b0);
   add_row(OP_READ,  16'h0004, 32'h0, na_pkg::NUM_TILES, 1'b1, 1'b0);
   add_row(OP_READ,  16'h0008, 32'h0, 32'h0, 1'b1, 1'b0);
   add_row(OP_READ,  16'h000c, 32'h0, feat, 1'b1, 1'b0);
   add_row(OP_READ,  16'h0010, 32'h0, 32'd4, 1'b1, 1'b0);  // tile 2, two cores each
   add_row(OP_READ,  16'h0018, 32'h0, na_pkg::CORES_PER_TILE, 1'b1, 1'b0);
   add_row(OP_READ,  16'h001c, 32'h0, na_pkg::GMEM_SIZE, 1'b1, 1'b0);
   add_row(OP_READ,  16'h0020, 32'h0, na_pkg::GMEM_TILE, 1'b1, 1'b0);
   add_row(OP_READ,  16'h0024, 32'h0, na_pkg::LMEM_SIZE, 1'b1, 1'b0);
   add_row(OP_READ,  16'h0028, 32'h0, na_pkg::NUM_CTS, 1'b1, 1'b0);
   add_row(OP_READ,  16'h0100, 32'h0, 32'h0, 1'b1, 1'b0);
   add_row(OP_WRITE, 16'h0004, 32'hffff_ffff, 32'h0, 1'b1, 1'b0);  // read-only, ignored
   add_row(OP_READ,  16'h0004, 32'h0, na_pkg::NUM_TILES, 1'b1, 1'b0);
   // ct list, even entry in the high half
   add_row(OP_READ,  16'h0200, 32'h0, {na_pkg::CT_LIST[0], na_pkg::CT_LIST[1]}, 1'b1, 1'b0);
   add_row(OP_READ,  16'h0204, 32'h0, {na_pkg::CT_LIST[2], 16'h0000}, 1'b1, 1'b0);
   add_row(OP_READ,  16'h0208, 32'h0, 32'h0, 1'b1, 1'b0);
   // unmapped regions
   add_row(OP_READ,  16'h2000, 32'h0, 32'h0, 1'b0, 1'b1);
   add_row(OP_WRITE, 16'h3108, 32'h1234_5678, 32'h0, 1'b0, 1'b1);  // aliases cdc setting
   add_row(OP_READ,  16'hf108, 32'h0, 32'h0, 1'b0, 1'b1);
   // clock domain setting
   add_row(OP_READ,  16'h0108, 32'h0, 32'(na_pkg::CDC_DEFAULT), 1'b1, 1'b0);
   add_row(OP_WRITE, 16'h0108, 32'hffff_fff3, 32'h0, 1'b1, 1'b0);
   add_row(OP_IDLE,  16'h0000, 32'h0, 32'h0, 1'b0, 1'b0);  // enable pulse here
   add_row(OP_READ,  16'h0108, 32'h0, 32'h3, 1'b1, 1'b0);
   // send strobe
   add_row(OP_WRITE, 16'h1000, 32'hcafe_0123, 32'h0, 1'b1, 1'b0);
   add_row(OP_IDLE,  16'h0000, 32'h0, 32'h0, 1'b0, 1'b0);
   add_row(OP_READ,  16'h1008, 32'h0, 32'h0, 1'b1, 1'b0);
   // rx queue in order, then empty
   add_row(OP_READ,  16'h1000, 32'h0, 32'h0, 1'b1, 1'b0);
   repeat (3) add_row(OP_INJECT, 16'h0000, 32'h0, 32'h0, 1'b0, 1'b0);
   add_row(OP_READ,  16'h1004, 32'h0, 32'h3, 1'b1, 1'b0);
   add_row(OP_READ,  16'h1000, 32'h0, 32'h0, 1'b1, 1'b0);
   add_row(OP_READ,  16'h1004, 32'h0, 32'h2, 1'b1, 1'b0);
   repeat (3) add_row(OP_READ, 16'h1000, 32'h0, 32'h0, 1'b1, 1'b0);  // last one empty
   add_row(OP_READ,  16'h1004, 32'h0, 32'h0, 1'b1, 1'b0);
   // overflow, ninth word dropped
   repeat (9) add_row(OP_INJECT, 16'h0000, 32'h0, 32'h0, 1'b0, 1'b0);
   add_row(OP_READ,  16'h1004, 32'h0, 32'h8000_0008, 1'b1, 1'b0);
   repeat (8) add_row(OP_READ, 16'h1000, 32'h0, 32'h0, 1'b1, 1'b0);
   add_row(OP_READ,  16'h1004, 32'h0, 32'h8000_0000, 1'b1, 1'b0);
   add_row(OP_WRITE, 16'h1004, 32'h0, 32'h0, 1'b1, 1'b0);
   add_row(OP_READ,  16'h1004, 32'h0, 32'h0, 1'b1, 1'b0);
endtask

//--- bench/na_tb.sv
// testbench for the network adapter slave, runs the stimulus table against na_top
// a queue model of injected words predicts what data reads pop
module na_tb;

   typedef enum logic [1:0] {OP_IDLE, OP_READ, OP_WRITE, OP_INJECT} op_t;

   typedef struct packed {
      op_t         op;
      logic [15:0] adr;    // byte address
      logic [31:0] wdata;
      logic [31:0] rdata;  // expected
      logic        ack;
      logic        err;
   } row_t;

   localparam logic [15:0] TB_TILE    = 16'd2;
   localparam int          PERIOD     = 100;
   localparam int          RST_CYCLES = 10;

   logic        clk = 1'b0;
   logic        rst;
   logic        bus_stb;
   logic        bus_we;
   logic [15:0] bus_adr;
   logic [31:0] bus_wdata;
   logic [31:0] bus_rdata;
   logic        bus_ack;
   logic        bus_err;
   logic [2:0]  cdc_conf;
   logic        cdc_enable;
   logic        noc_out_valid;
   logic [31:0] noc_out_data;
   logic        noc_in_valid;
   logic [31:0] noc_in_data;

   row_t        rows [$];
   int          num_rows = 0;
   logic [31:0] rx_model [$];  // words the dut should still hold
   integer      seed = 32'hb7c5f786;

   always #(PERIOD / 2) clk = ~clk;

   na_top #(
      .tile_id (TB_TILE)
   ) uut (
      .clk           (clk),
      .rst           (rst),
      .bus_stb       (bus_stb),
      .bus_we        (bus_we),
      .bus_adr       (bus_adr),
      .bus_wdata     (bus_wdata),
      .bus_rdata     (bus_rdata),
      .bus_ack       (bus_ack),
      .bus_err       (bus_err),
      .cdc_conf      (cdc_conf),
      .cdc_enable    (cdc_enable),
      .noc_out_valid (noc_out_valid),
      .noc_out_data  (noc_out_data),
      .noc_in_valid  (noc_in_valid),
      .noc_in_data   (noc_in_data)
   );

   task automatic add_row(input op_t op, input logic [15:0] adr, input logic [31:0] wdata,
                          input logic [31:0] rdata, input logic ack, input logic err);
      row_t r;
      r = '{op, adr, wdata, rdata, ack, err};
      rows.push_back(r);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         $display("** FAIL **");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   `include "na_tb_table.svh"

   initial begin
      row_t        r;
      logic [31:0] exp_rdata;
      logic [31:0] inj;
      logic [2:0]  exp_cdc;
      logic        cdc_wr_prev;
      logic        tx_wr_prev;
      logic [31:0] tx_data_prev;
      rst          = 1'b1;
      bus_stb      = 1'b0;
      bus_we       = 1'b0;
      bus_adr      = '0;
      bus_wdata    = '0;
      noc_in_valid = 1'b0;
      noc_in_data  = '0;
      build_table();
      num_rows     = rows.size();
      exp_cdc      = na_pkg::CDC_DEFAULT;
      cdc_wr_prev  = 1'b0;
      tx_wr_prev   = 1'b0;
      tx_data_prev = '0;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < num_rows; i++) begin
         r = rows[i];
         bus_stb      <= (r.op == OP_READ) || (r.op == OP_WRITE);
         bus_we       <= (r.op == OP_WRITE);
         bus_adr      <= r.adr;
         bus_wdata    <= r.wdata;
         noc_in_valid <= (r.op == OP_INJECT);
         noc_in_data  <= '0;
         if (r.op == OP_INJECT) begin
            inj = $random(seed);
            noc_in_data <= inj;
            if (rx_model.size() < na_pkg::RX_DEPTH) begin
               rx_model.push_back(inj);  // full queue drops it
            end
         end
         exp_rdata = r.rdata;
         if (r.op == OP_READ && r.adr == 16'h1000) begin
            exp_rdata = 32'h0;  // empty queue reads zero
            if (rx_model.size() > 0) begin
               exp_rdata = rx_model.pop_front();
            end
         end
         @(negedge clk);  // answers settled mid cycle
         check_value("bus_ack", 32'(bus_ack), 32'(r.ack));
         check_value("bus_err", 32'(bus_err), 32'(r.err));
         if (r.op == OP_READ || r.err) begin
            check_value("bus_rdata", bus_rdata, exp_rdata);
         end
         // registered outputs show the previous row
         check_value("cdc_enable", 32'(cdc_enable), 32'(cdc_wr_prev));
         check_value("cdc_conf", 32'(cdc_conf), 32'(exp_cdc));
         check_value("noc_out_valid", 32'(noc_out_valid), 32'(tx_wr_prev));
         if (tx_wr_prev) begin
            check_value("noc_out_data", noc_out_data, tx_data_prev);
         end
         cdc_wr_prev  = (r.op == OP_WRITE) && (r.adr == 16'h0108);
         tx_wr_prev   = (r.op == OP_WRITE) && (r.adr == 16'h1000);
         tx_data_prev = r.wdata;
         if (cdc_wr_prev) begin
            exp_cdc = r.wdata[2:0];  // seen from the next row on
         end
         @(posedge clk);
      end
      $display("** PASS **");
      $finish;
   end

   // table length plus reset plus slack
   initial begin
      wait (num_rows > 0);
      #((RST_CYCLES + num_rows + 20) * PERIOD);
      $display("** FAIL **");
      $fatal(1, "watchdog expired before the table run finished");
   end

endmodule

//--- logic/na_addr_decode.sv
// splits the tile bus into conf and message regions by the upper address nibble
// purely combinational, answers come back in the request cycle
module na_addr_decode (
   input  logic          bus_stb,
   input  logic          bus_we,
   input  na_pkg::adr_t  bus_adr,
   input  na_pkg::word_t bus_wdata,
   output na_pkg::word_t bus_rdata,
   output logic          bus_ack,
   output logic          bus_err,
   na_bus_if.decoder     conf,
   na_bus_if.decoder     mp
);

   logic sel_conf;  // region 0
   logic sel_mp;    // region 1

   assign sel_conf = (bus_adr[15:12] == na_pkg::REGION_CONF);
   assign sel_mp   = (bus_adr[15:12] == na_pkg::REGION_MP);

   // request fan-out, strobe only to the selected block
   assign conf.stb   = bus_stb & sel_conf;
   assign conf.we    = bus_we;
   assign conf.adr   = bus_adr;
   assign conf.wdata = bus_wdata;

   assign mp.stb   = bus_stb & sel_mp;
   assign mp.we    = bus_we;
   assign mp.adr   = bus_adr;
   assign mp.wdata = bus_wdata;

   // answer mux
   always_comb begin
      bus_rdata = '0;  // zero outside both regions
      bus_ack   = 1'b0;
      if (sel_conf) begin
         bus_rdata = conf.rdata;
         bus_ack   = conf.ack;
      end else if (sel_mp) begin
         bus_rdata = mp.rdata;
         bus_ack   = mp.ack;
      end
   end

   // nibble 2..15 is unmapped
   assign bus_err = bus_stb & ~(sel_conf | sel_mp);

   // a strobe gets exactly one answer, none without a strobe
   always_comb begin
      a_ack_err_excl: assert (bus_stb ? (bus_ack != bus_err) : !(bus_ack || bus_err))
         else $error("ack and err do not match the strobe at adr %h", bus_adr);
   end

endmodule

//--- logic/na_bus_if.sv
// one bus request and its same-cycle answer between decoder and a register block
// decoder drives the request side, the target answers with rdata and ack
interface na_bus_if;

   logic          stb;    // one-cycle request strobe
   logic          we;     // high for write
   na_pkg::adr_t  adr;    // full byte address
   na_pkg::word_t wdata;
   na_pkg::word_t rdata;  // combinational answer
   logic          ack;

   // address decoder side
   modport decoder (
      output stb,
      output we,
      output adr,
      output wdata,
      input  rdata,
      input  ack
   );

   // register block side
   modport target (
      input  stb,
      input  we,
      input  adr,
      input  wdata,
      output rdata,
      output ack
   );

endinterface

//--- logic/na_conf.sv
// read-only system facts for tile software plus the writable clock domain setting
// lives in region 0 behind the address decoder
module na_conf #(
   parameter na_pkg::tile_id_t tile_id = '0
) (
   input  logic              clk,
   input  logic              rst,
   na_bus_if.target          bus,
   output na_pkg::cdc_conf_t cdc_conf,
   output logic              cdc_enable
);

   na_pkg::reg_idx_t reg_idx;    // word address
   na_pkg::reg_idx_t ct_word;    // word inside the ct list
   logic             ct_hit;     // at or above the list base
   na_pkg::word_t    core_base;
   na_pkg::word_t    rdata;
   logic             cdc_wr;

   assign reg_idx = bus.adr[11:2];
   assign ct_hit  = ({4'h0, bus.adr[11:0]} >= na_pkg::CTLIST_BASE);
   assign ct_word = bus.adr[11:2] - na_pkg::reg_idx_t'(na_pkg::CTLIST_BASE >> 2);

   // first core of this tile
   assign core_base = na_pkg::word_t'(tile_id) * na_pkg::word_t'(na_pkg::CORES_PER_TILE);

   // every strobe in region 0 is answered
   assign bus.ack   = bus.stb;
   assign bus.rdata = rdata;

   always_comb begin
      rdata = '0;  // undefined words read zero
      if (ct_hit) begin
         // entry n in word n/2, even entries high half
         for (int i = 0; i < na_pkg::NUM_CTS; i++) begin
            if (ct_word == na_pkg::reg_idx_t'(i / 2)) begin
               if (i % 2 == 0) begin
                  rdata[31:16] = na_pkg::CT_LIST[i];
               end else begin
                  rdata[15:0] = na_pkg::CT_LIST[i];
               end
            end
         end
      end else begin
         case (reg_idx)
            na_pkg::REG_TILEID: begin
               rdata = na_pkg::word_t'(tile_id);
            end
            na_pkg::REG_NUMTILES: begin
               rdata = na_pkg::word_t'(na_pkg::NUM_TILES);
            end
            na_pkg::REG_CONF: begin
               rdata[na_pkg::CONF_BIT_MPSIMPLE] = na_pkg::ENABLE_MPSIMPLE;
               rdata[na_pkg::CONF_BIT_DMA]      = na_pkg::ENABLE_DMA;
            end
            na_pkg::REG_COREBASE: begin
               rdata = core_base;
            end
            na_pkg::REG_DOMAIN_NUMCORES: begin
               rdata = na_pkg::word_t'(na_pkg::CORES_PER_TILE);
            end
            na_pkg::REG_GMEM_SIZE: begin
               rdata = na_pkg::word_t'(na_pkg::GMEM_SIZE);
            end
            na_pkg::REG_GMEM_TILE: begin
               rdata = na_pkg::word_t'(na_pkg::GMEM_TILE);
            end
            na_pkg::REG_LMEM_SIZE: begin
               rdata = na_pkg::word_t'(na_pkg::LMEM_SIZE);
            end
            na_pkg::REG_NUMCTS: begin
               rdata = na_pkg::word_t'(na_pkg::NUM_CTS);
            end
            na_pkg::REG_CDC_CONF: begin
               rdata = na_pkg::word_t'(cdc_conf);  // current setting
            end
            default: begin
               rdata = '0;
            end
         endcase
      end
   end

   // only writable register in the block
   assign cdc_wr = bus.stb & bus.we & ~ct_hit & (reg_idx == na_pkg::REG_CDC_CONF);

   always_ff @(posedge clk) begin
      if (rst) begin
         cdc_conf   <= na_pkg::CDC_DEFAULT;
         cdc_enable <= 1'b0;
      end else begin
         cdc_enable <= cdc_wr;  // one-cycle pulse after the write
         if (cdc_wr) begin
            cdc_conf <= bus.wdata[2:0];
         end
      end
   end

   // setting only moves together with its enable pulse
   a_cdc_pulse: assert property (@(posedge clk) disable iff (rst)
      !cdc_enable |-> $stable(cdc_conf))
      else $error("cdc_conf changed without cdc_enable");

endmodule

//--- logic/na_mp_simple.sv
// simple message endpoint: bus writes leave as one-word strobes
// arriving words queue up for software to read along with a status word
module na_mp_simple (
   input  logic          clk,
   input  logic          rst,
   na_bus_if.target      bus,
   output logic          noc_out_valid,
   output na_pkg::word_t noc_out_data,
   input  logic          noc_in_valid,
   input  na_pkg::word_t noc_in_data
);

   na_pkg::word_t       rx_mem [na_pkg::RX_DEPTH];  // circular buffer
   na_pkg::rx_ptr_t     rx_rd_ptr;                  // oldest word
   na_pkg::rx_ptr_t     rx_wr_ptr;                  // next free slot
   na_pkg::fifo_count_t rx_count;
   logic                rx_overflow;                // sticky
   logic                rx_full;
   logic                rx_empty;
   logic                rx_push;
   logic                rx_pop;
   logic                sel_data;
   logic                sel_status;
   logic                tx_wr;
   logic                ovf_clr;
   na_pkg::word_t       rdata;

   assign sel_data   = (bus.adr[11:0] == na_pkg::MP_DATA);
   assign sel_status = (bus.adr[11:0] == na_pkg::MP_STATUS);

   assign rx_full  = (rx_count == na_pkg::fifo_count_t'(na_pkg::RX_DEPTH));
   assign rx_empty = (rx_count == '0);

   assign tx_wr   = bus.stb & bus.we & sel_data;
   assign ovf_clr = bus.stb & bus.we & sel_status;  // any value clears
   assign rx_push = noc_in_valid & ~rx_full;        // no back-pressure
   assign rx_pop  = bus.stb & ~bus.we & sel_data & ~rx_empty;

   // every strobe in region 1 is answered
   assign bus.ack   = bus.stb;
   assign bus.rdata = rdata;

   always_comb begin
      rdata = '0;  // also the empty-queue data read
      if (sel_data && !rx_empty) begin
         rdata = rx_mem[rx_rd_ptr];
      end else if (sel_status) begin
         rdata     = na_pkg::word_t'(rx_count);
         rdata[31] = rx_overflow;
      end
   end

   // send side
   always_ff @(posedge clk) begin
      if (rst) begin
         noc_out_valid <= 1'b0;
      end else begin
         noc_out_valid <= tx_wr;  // one cycle per write
      end
   end

   always_ff @(posedge clk) begin
      if (tx_wr) begin
         noc_out_data <= bus.wdata;
      end
   end

   // rx storage
   always_ff @(posedge clk) begin
      if (rx_push) begin
         rx_mem[rx_wr_ptr] <= noc_in_data;
      end
   end

   // rx pointers, fill level and overflow
   always_ff @(posedge clk) begin
      if (rst) begin
         rx_rd_ptr   <= '0;
         rx_wr_ptr   <= '0;
         rx_count    <= '0;
         rx_overflow <= 1'b0;
      end else begin
         if (rx_push) begin
            rx_wr_ptr <= rx_wr_ptr + 1'b1;  // wraps at depth
         end
         if (rx_pop) begin
            rx_rd_ptr <= rx_rd_ptr + 1'b1;
         end
         case ({rx_push, rx_pop})
            2'b10:   rx_count <= rx_count + 1'b1;
            2'b01:   rx_count <= rx_count - 1'b1;
            default: rx_count <= rx_count;  // none or both
         endcase
         if (noc_in_valid && rx_full) begin
            rx_overflow <= 1'b1;  // dropped word wins over clear
         end else if (ovf_clr) begin
            rx_overflow <= 1'b0;
         end
      end
   end

   a_count_bound: assert property (@(posedge clk) disable iff (rst)
      rx_count <= na_pkg::fifo_count_t'(na_pkg::RX_DEPTH))
      else $error("rx count above queue depth");

   // pointers must agree with the count that a word is there
   a_pop_nonempty: assert property (@(posedge clk) disable iff (rst)
      rx_pop |-> ((rx_rd_ptr != rx_wr_ptr) || rx_full))
      else $error("pop from an empty rx queue");

endmodule

//--- logic/na_pkg.sv
// types, address map and system constants of the network adapter slave
// every design file refers to these by scoped name
package na_pkg;

   // widths with a meaning
   typedef logic [31:0] word_t;        // bus data word
   typedef logic [15:0] adr_t;         // bus byte address
   typedef logic [15:0] tile_id_t;     // tile number and ct list entry
   typedef logic [2:0]  cdc_conf_t;    // clock domain setting
   typedef logic [3:0]  fifo_count_t;  // rx fill level 0..8
   typedef logic [9:0]  reg_idx_t;     // word index inside a region

   // system description
   localparam int NUM_TILES      = 4;
   localparam int CORES_PER_TILE = 2;
   localparam int GMEM_SIZE      = 32'h0010_0000;  // 1 MiB shared memory
   localparam int GMEM_TILE      = 3;              // memory tile
   localparam int LMEM_SIZE      = 32'h0000_8000;  // 32 KiB per tile
   localparam int NUM_CTS        = 3;

   // compute tiles, everything except the memory tile
   localparam tile_id_t CT_LIST [NUM_CTS] = '{
      16'd0,
      16'd1,
      16'd2
   };

   // feature bits
   localparam bit ENABLE_MPSIMPLE   = 1'b1;
   localparam bit ENABLE_DMA        = 1'b0;  // no dma in this tile
   localparam int CONF_BIT_MPSIMPLE = 0;
   localparam int CONF_BIT_DMA      = 1;

   // clock domain setting after reset
   localparam cdc_conf_t CDC_DEFAULT = 3'd4;

   // rx queue
   localparam int RX_DEPTH = 8;
   localparam int RX_PTR_W = $clog2(RX_DEPTH);
   typedef logic [RX_PTR_W-1:0] rx_ptr_t;  // circular buffer index

   // regions, selected by adr[15:12]
   localparam logic [3:0] REGION_CONF = 4'h0;
   localparam logic [3:0] REGION_MP   = 4'h1;

   // conf word indices, adr[11:2]
   localparam reg_idx_t REG_TILEID          = 10'd0;
   localparam reg_idx_t REG_NUMTILES        = 10'd1;
   localparam reg_idx_t REG_CONF            = 10'd3;
   localparam reg_idx_t REG_COREBASE        = 10'd4;
   localparam reg_idx_t REG_DOMAIN_NUMCORES = 10'd6;
   localparam reg_idx_t REG_GMEM_SIZE       = 10'd7;
   localparam reg_idx_t REG_GMEM_TILE       = 10'd8;
   localparam reg_idx_t REG_LMEM_SIZE       = 10'd9;
   localparam reg_idx_t REG_NUMCTS          = 10'd10;
   localparam reg_idx_t REG_CDC_CONF        = 10'h042;  // byte 0x108

   // ct list, two entries per word
   localparam adr_t CTLIST_BASE = 16'h0200;

   // message endpoint byte offsets inside region 1
   localparam logic [11:0] MP_DATA   = 12'h000;
   localparam logic [11:0] MP_STATUS = 12'h004;

endpackage

//--- logic/na_top.sv
// network adapter slave of one tile: decoder, conf block and message endpoint
// bus and message signals are plain ports for the tile to hook up
module na_top #(
   parameter na_pkg::tile_id_t tile_id = '0
) (
   input  logic              clk,
   input  logic              rst,
   // tile bus
   input  logic              bus_stb,
   input  logic              bus_we,
   input  na_pkg::adr_t      bus_adr,
   input  na_pkg::word_t     bus_wdata,
   output na_pkg::word_t     bus_rdata,
   output logic              bus_ack,
   output logic              bus_err,
   // clock domain control
   output na_pkg::cdc_conf_t cdc_conf,
   output logic              cdc_enable,
   // message strobes
   output logic              noc_out_valid,
   output na_pkg::word_t     noc_out_data,
   input  logic              noc_in_valid,
   input  na_pkg::word_t     noc_in_data
);

   na_bus_if conf_bus ();  // region 0
   na_bus_if mp_bus ();    // region 1

   na_addr_decode u_decode (
      .bus_stb   (bus_stb),
      .bus_we    (bus_we),
      .bus_adr   (bus_adr),
      .bus_wdata (bus_wdata),
      .bus_rdata (bus_rdata),
      .bus_ack   (bus_ack),
      .bus_err   (bus_err),
      .conf      (conf_bus.decoder),
      .mp        (mp_bus.decoder)
   );

   na_conf #(
      .tile_id (tile_id)
   ) u_conf (
      .clk        (clk),
      .rst        (rst),
      .bus        (conf_bus.target),
      .cdc_conf   (cdc_conf),
      .cdc_enable (cdc_enable)
   );

   na_mp_simple u_mp (
      .clk           (clk),
      .rst           (rst),
      .bus           (mp_bus.target),
      .noc_out_valid (noc_out_valid),
      .noc_out_data  (noc_out_data),
      .noc_in_valid  (noc_in_valid),
      .noc_in_data   (noc_in_data)
   );

endmodule

//--- na_subsys.f
+incdir+bench
logic/na_pkg.sv
logic/na_bus_if.sv
logic/na_addr_decode.sv
logic/na_conf.sv
logic/na_mp_simple.sv
logic/na_top.sv
bench/na_tb.sv
